// ==== source/dcache_params.svh ====
// ###################################################################
// Cache geometry shared by the package and the RTL
// Victim selection keeps one bit per set, so DC_WAYS must stay at 2
// Derived widths assume power-of-two sets and words per line
// ###################################################################
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

`define DC_WAYS   2
`define DC_SETS   16
`define DC_WORDS  4
`define DC_ADDR_W 32
`define DC_WORD_W 32

// Derived field widths of a byte address
`define DC_BOFF_W $clog2(`DC_WORD_W / 8)
`define DC_WOFF_W $clog2(`DC_WORDS)
`define DC_LOFF_W (`DC_BOFF_W + `DC_WOFF_W)
`define DC_SET_W  $clog2(`DC_SETS)
`define DC_TAG_W  (`DC_ADDR_W - `DC_SET_W - `DC_LOFF_W)
`define DC_LINE_W (`DC_WORDS * `DC_WORD_W)

`endif

// ==== source/dcache_pkg.sv ====
// ###################################################################
// Types shared by the L1 data cache RTL
// Address layout is tag, set index, word offset, byte offset
// ###################################################################
`include "dcache_params.svh"

package dcache_pkg;

  // Address fields
  typedef logic [`DC_ADDR_W-1:0]              addr_t;
  typedef logic [`DC_ADDR_W-`DC_LOFF_W-1:0]   line_addr_t;
  typedef logic [`DC_SET_W-1:0]               set_idx_t;
  typedef logic [`DC_TAG_W-1:0]               tag_t;
  typedef logic [`DC_WOFF_W-1:0]              word_off_t;

  // Data and byte enables
  typedef logic [`DC_WORD_W-1:0]              word_t;
  typedef logic [`DC_WORD_W/8-1:0]            word_be_t;
  typedef logic [`DC_LINE_W-1:0]              line_t;
  typedef logic [`DC_LINE_W/8-1:0]            line_be_t;

  // One bit per way
  typedef logic [`DC_WAYS-1:0]                way_vec_t;

  // Source that owns d0 in a cycle
  typedef enum logic [2:0] {
    SrcNone,
    SrcSweep,
    SrcD1,
    SrcL2,
    SrcLsq
  } d0_src_e;

  // Operation carried from d0 into d1
  typedef enum logic [2:0] {
    OpIdle,
    OpLoad,
    OpStore,
    OpRefill,
    OpSweep,
    OpLineWr
  } d0_op_e;

endpackage

// ==== source/dcache_stage_if.sv ====
// ###################################################################
// Link between the d0 and d1 stages
// No ready goes back to d0, since d1 takes every request
// ###################################################################
interface dcache_stage_if;
  import dcache_pkg::*;

  // Registered request from d0
  d0_op_e   op;
  addr_t    addr;
  word_t    wdata;
  word_be_t be;

  // Store-hit write-back from d1
  logic     wr_valid;
  way_vec_t wr_way;
  set_idx_t wr_set;
  line_t    wr_line;
  word_be_t wr_be;

  // Pending L2 request or busy MSHR
  logic     stalled;

  modport d0 (
    output op, addr, wdata, be,
    input  wr_valid, wr_way, wr_set, wr_line, wr_be, stalled
  );

  modport d1 (
    input  op, addr, wdata, be,
    output wr_valid, wr_way, wr_set, wr_line, wr_be, stalled
  );

endinterface

// ==== source/dcache_d0_arbiter.sv ====
// ###################################################################
// Fixed-priority scheduler of the d0 stage
// Order is sweep, d1 write-back, L2 answer, LSQ request
// Readies never depend on the valid of the same source
// ###################################################################
module dcache_d0_arbiter (
  input  logic                sweep_i,
  input  logic                d1_wr_i,
  input  logic                l2_valid_i,
  input  logic                lsq_valid_i,
  input  logic                stalled_i,
  output dcache_pkg::d0_src_e winner_o,
  output logic                lsq_ready_o,
  output logic                l2_ready_o
);
  import dcache_pkg::*;

  logic lsq_free;

  // L2 answers only wait for the sweep and write-backs
  assign l2_ready_o = !sweep_i && !d1_wr_i;

  // LSQ needs an empty cycle and an unstalled d1
  assign lsq_free    = l2_ready_o && !l2_valid_i && !stalled_i;
  assign lsq_ready_o = lsq_free;

  // Sweep and write-back never overlap a stall
  // A stall comes from a miss, which blocks the LSQ
  always_comb begin
    if (sweep_i) begin
      winner_o = SrcSweep;
    end else if (d1_wr_i) begin
      winner_o = SrcD1;
    end else if (l2_valid_i) begin
      winner_o = SrcL2;
    end else if (lsq_valid_i && lsq_free) begin
      winner_o = SrcLsq;
    end else begin
      winner_o = SrcNone;
    end
  end

endmodule

// ==== source/dcache_d0_mem_ctrl.sv ====
// ###################################################################
// Tag and data memory control per d0 operation
// Data enable doubles as the read strobe of a way
// ###################################################################
`include "dcache_params.svh"

module dcache_d0_mem_ctrl (
  input  dcache_pkg::d0_op_e    op_i,
  input  dcache_pkg::way_vec_t  wr_way_i,
  input  dcache_pkg::way_vec_t  refill_way_i,
  input  dcache_pkg::word_off_t byte_off_i,
  input  dcache_pkg::line_be_t  be_i,
  output dcache_pkg::way_vec_t  tag_we_o,
  output dcache_pkg::way_vec_t  data_en_o,
  output dcache_pkg::line_be_t  line_be_o,
  output logic                  rd_en_o
);
  import dcache_pkg::*;

  always_comb begin
    tag_we_o  = '0;
    data_en_o = '0;
    line_be_o = '0;
    rd_en_o   = 1'b0;
    case (op_i)
      // Invalidate the set in every way
      OpSweep: tag_we_o = '1;
      // Whole line, tag and valid into the MSHR way
      OpRefill: begin
        tag_we_o  = refill_way_i;
        data_en_o = refill_way_i;
        line_be_o = '1;
      end
      // Store bytes moved to their word slot
      OpLineWr: begin
        data_en_o = wr_way_i;
        line_be_o = be_i << ((`DC_WORD_W / 8) * byte_off_i);
      end
      // Read every way for the tag compare
      OpLoad, OpStore: begin
        data_en_o = '1;
        rd_en_o   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== source/dcache_d0.sv ====
// ###################################################################
// d0 stage of the L1 data cache
// Runs a set sweep after reset before any request is taken
// An L2 answer that misses the MSHR is taken and dropped
// The write-back reuses the store still held in the d0 register
// ###################################################################
`include "dcache_params.svh"

module dcache_d0 (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clr_i,
  input  logic                   lsq_req_valid_i,
  output logic                   lsq_req_ready_o,
  input  logic                   lsq_req_we_i,
  input  dcache_pkg::addr_t      lsq_req_addr_i,
  input  dcache_pkg::word_t      lsq_req_wdata_i,
  input  dcache_pkg::word_be_t   lsq_req_be_i,
  input  logic                   l2_ans_valid_i,
  output logic                   l2_ans_ready_o,
  input  dcache_pkg::line_addr_t l2_ans_addr_i,
  input  dcache_pkg::line_t      l2_ans_line_i,
  output logic                   lsq_wup_valid_o,
  output dcache_pkg::line_addr_t lsq_wup_addr_o,
  dcache_stage_if.d0             stage,
  input  dcache_pkg::way_vec_t   mshr_way_i,
  input  dcache_pkg::line_addr_t mshr_addr_i,
  output dcache_pkg::set_idx_t   mem_set_o,
  output dcache_pkg::tag_t       mem_tag_o,
  output logic                   mem_valid_o,
  output dcache_pkg::line_t      mem_line_o,
  output dcache_pkg::line_be_t   mem_line_be_o,
  output dcache_pkg::way_vec_t   mem_tag_we_o,
  output dcache_pkg::way_vec_t   mem_data_en_o
);
  import dcache_pkg::*;

  logic     sweep_q;
  set_idx_t sweep_cnt_q;
  d0_src_e  winner;
  d0_op_e   op;
  logic     refill_hit;
  logic     rd_en;
  logic     reg_load;
  addr_t    next_addr;

  // Sweep one set per cycle from reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sweep_q     <= 1'b1;
      sweep_cnt_q <= '0;
    end else if (sweep_q) begin
      sweep_cnt_q <= sweep_cnt_q + 1'b1;
      if (sweep_cnt_q == set_idx_t'(`DC_SETS - 1)) begin
        sweep_q <= 1'b0;
      end
    end
  end

  dcache_d0_arbiter arbiter_inst (
    .sweep_i     (sweep_q),
    .d1_wr_i     (stage.wr_valid),
    .l2_valid_i  (l2_ans_valid_i),
    .lsq_valid_i (lsq_req_valid_i),
    .stalled_i   (stage.stalled),
    .winner_o    (winner),
    .lsq_ready_o (lsq_req_ready_o),
    .l2_ready_o  (l2_ans_ready_o)
  );

  // MSHR way is zero while no miss is outstanding
  assign refill_hit = |mshr_way_i && (l2_ans_addr_i == mshr_addr_i);

  // Winner to operation
  always_comb begin
    case (winner)
      SrcSweep: op = OpSweep;
      SrcD1:    op = OpLineWr;
      SrcL2:    op = refill_hit ? OpRefill : OpIdle;
      SrcLsq:   op = lsq_req_we_i ? OpStore : OpLoad;
      default:  op = OpIdle;
    endcase
  end

  // Memory set, tag and line from the winner
  always_comb begin
    mem_set_o   = lsq_req_addr_i[`DC_LOFF_W +: `DC_SET_W];
    mem_tag_o   = l2_ans_addr_i[`DC_SET_W +: `DC_TAG_W];
    mem_valid_o = 1'b1;
    mem_line_o  = l2_ans_line_i;
    next_addr   = lsq_req_addr_i;
    case (winner)
      SrcSweep: begin
        mem_set_o   = sweep_cnt_q;
        mem_tag_o   = '0;
        mem_valid_o = 1'b0;
        next_addr   = addr_t'({sweep_cnt_q, {`DC_LOFF_W{1'b0}}});
      end
      SrcD1: begin
        mem_set_o  = stage.wr_set;
        mem_line_o = stage.wr_line;
      end
      SrcL2: begin
        mem_set_o = l2_ans_addr_i[`DC_SET_W-1:0];
        next_addr = {l2_ans_addr_i, {`DC_LOFF_W{1'b0}}};
      end
      default: ;
    endcase
  end

  dcache_d0_mem_ctrl mem_ctrl_inst (
    .op_i         (op),
    .wr_way_i     (stage.wr_way),
    .refill_way_i (mshr_way_i),
    .byte_off_i   (stage.addr[`DC_BOFF_W +: `DC_WOFF_W]),
    .be_i         (line_be_t'(stage.wr_be)),
    .tag_we_o     (mem_tag_we_o),
    .data_en_o    (mem_data_en_o),
    .line_be_o    (mem_line_be_o),
    .rd_en_o      (rd_en)
  );

  // d1 only needs reads, refills and sweeps
  assign reg_load = rd_en || (op == OpRefill) || (op == OpSweep);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage.op <= OpIdle;
    end else if (clr_i || !reg_load) begin
      stage.op <= OpIdle;
    end else begin
      stage.op <= op;
    end
  end

  // Payload kept until the next useful operation
  always_ff @(posedge clk_i) begin
    if (reg_load) begin
      stage.addr  <= next_addr;
      stage.wdata <= lsq_req_wdata_i;
      stage.be    <= lsq_req_be_i;
    end
  end

  // Wake-up while the matching answer is taken
  assign lsq_wup_valid_o = (op == OpRefill);
  assign lsq_wup_addr_o  = l2_ans_addr_i;

endmodule

// ==== source/dcache_way_mem.sv ====
// ###################################################################
// One way of tag, valid and data storage
// Outputs follow the set of the previous cycle
// Line output only updates on a data access
// ###################################################################
`include "dcache_params.svh"

module dcache_way_mem (
  input  logic                 clk_i,
  input  dcache_pkg::set_idx_t set_i,
  input  dcache_pkg::tag_t     tag_i,
  input  logic                 valid_i,
  input  dcache_pkg::line_t    line_i,
  input  dcache_pkg::line_be_t line_be_i,
  input  logic                 tag_we_i,
  input  logic                 data_en_i,
  output dcache_pkg::tag_t     tag_o,
  output logic                 valid_o,
  output dcache_pkg::line_t    line_o
);
  import dcache_pkg::*;

  tag_t  tag_mem   [`DC_SETS];
  logic  valid_mem [`DC_SETS];
  line_t data_mem  [`DC_SETS];

  // Tag and valid, read every cycle
  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_mem[set_i]   <= tag_i;
      valid_mem[set_i] <= valid_i;
    end
    tag_o   <= tag_mem[set_i];
    valid_o <= valid_mem[set_i];
  end

  // Read-first data with byte enables
  always_ff @(posedge clk_i) begin
    if (data_en_i) begin
      for (int b = 0; b < `DC_LINE_W / 8; b++) begin
        if (line_be_i[b]) begin
          data_mem[set_i][8*b +: 8] <= line_i[8*b +: 8];
        end
      end
      line_o <= data_mem[set_i];
    end
  end

endmodule

// ==== source/dcache_d1.sv ====
// ###################################################################
// d1 stage of the L1 data cache
// Single MSHR for one load miss and no hit-under-miss
// Store misses go to L2 as word writes, without allocation
// Victim bit per set supports two ways only
// ###################################################################
`include "dcache_params.svh"

module dcache_d1 (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clr_i,
  dcache_stage_if.d1                          stage,
  input  dcache_pkg::tag_t  [`DC_WAYS-1:0]    tag_vec_i,
  input  dcache_pkg::way_vec_t                valid_vec_i,
  input  dcache_pkg::line_t [`DC_WAYS-1:0]    line_vec_i,
  output logic                                lsq_rsp_valid_o,
  output logic                                lsq_rsp_hit_o,
  output dcache_pkg::word_t                   lsq_rsp_data_o,
  output logic                                l2_req_valid_o,
  input  logic                                l2_req_ready_i,
  output logic                                l2_req_we_o,
  output dcache_pkg::addr_t                   l2_req_addr_o,
  output dcache_pkg::word_t                   l2_req_wdata_o,
  output dcache_pkg::word_be_t                l2_req_be_o,
  output dcache_pkg::way_vec_t                mshr_way_o,
  output dcache_pkg::line_addr_t              mshr_addr_o
);
  import dcache_pkg::*;

  set_idx_t   set;
  tag_t       tag;
  word_off_t  woff;
  logic       is_load;
  logic       is_store;
  logic       refill_done;
  way_vec_t   hit_vec;
  way_vec_t   victim_vec;
  logic       hit;
  logic       issue;
  line_t      hit_line;
  word_t      hit_word;
  word_t      merged_word;
  line_t      merged_line;
  logic [`DC_SETS-1:0] victim_q;
  logic       mshr_busy_q;
  logic       mshr_active;
  way_vec_t   mshr_way_q;
  line_addr_t mshr_addr_q;
  logic       l2_pend_q;
  logic       l2_we_q;
  addr_t      l2_addr_q;
  word_t      l2_wdata_q;
  word_be_t   l2_be_q;
  addr_t      l2_addr;

  assign set         = stage.addr[`DC_LOFF_W +: `DC_SET_W];
  assign tag         = stage.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign woff        = stage.addr[`DC_BOFF_W +: `DC_WOFF_W];
  assign is_load     = (stage.op == OpLoad);
  assign is_store    = (stage.op == OpStore);
  assign refill_done = (stage.op == OpRefill);

  // Tag compare and hit line
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      hit_vec[w] = valid_vec_i[w] && (tag_vec_i[w] == tag);
      if (hit_vec[w]) begin
        hit_line = hit_line | line_vec_i[w];
      end
    end
  end

  assign hit      = |hit_vec;
  assign hit_word = hit_line[woff*`DC_WORD_W +: `DC_WORD_W];

  // Store data merged into the hit line
  always_comb begin
    for (int b = 0; b < `DC_WORD_W / 8; b++) begin
      merged_word[8*b +: 8] = stage.be[b] ? stage.wdata[8*b +: 8] : hit_word[8*b +: 8];
    end
    merged_line = hit_line;
    merged_line[woff*`DC_WORD_W +: `DC_WORD_W] = merged_word;
  end

  // Lowest invalid way, else the set's victim bit
  always_comb begin
    victim_vec = '0;
    victim_vec[victim_q[set]] = 1'b1;
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (!valid_vec_i[w]) begin
        victim_vec = way_vec_t'(1) << w;
      end
    end
  end

  // One-cycle response to every load or store
  assign lsq_rsp_valid_o = is_load || is_store;
  assign lsq_rsp_hit_o   = hit;
  assign lsq_rsp_data_o  = hit_word;

  assign stage.wr_valid = is_store && hit;
  assign stage.wr_way   = hit_vec;
  assign stage.wr_set   = set;
  assign stage.wr_line  = merged_line;
  assign stage.wr_be    = stage.be;

  // Any miss goes to L2
  assign issue = (is_load || is_store) && !hit;

  // Line address for loads, word address for stores
  assign l2_addr = is_store ?
      {stage.addr[`DC_ADDR_W-1:`DC_BOFF_W], {`DC_BOFF_W{1'b0}}} :
      {stage.addr[`DC_ADDR_W-1:`DC_LOFF_W], {`DC_LOFF_W{1'b0}}};

  assign l2_req_valid_o = l2_pend_q || issue;
  assign l2_req_we_o    = l2_pend_q ? l2_we_q : is_store;
  assign l2_req_addr_o  = l2_pend_q ? l2_addr_q : l2_addr;
  assign l2_req_wdata_o = l2_pend_q ? l2_wdata_q : stage.wdata;
  assign l2_req_be_o    = l2_pend_q ? l2_be_q : stage.be;

  // Refill in d1 already frees the MSHR for d0
  assign mshr_active   = mshr_busy_q && !refill_done;
  assign mshr_way_o    = mshr_active ? mshr_way_q : '0;
  assign mshr_addr_o   = mshr_addr_q;
  assign stage.stalled = l2_pend_q || mshr_active || issue;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      l2_pend_q   <= 1'b0;
      mshr_busy_q <= 1'b0;
    end else if (clr_i) begin
      l2_pend_q   <= 1'b0;
      mshr_busy_q <= 1'b0;
    end else begin
      // Hold the request until L2 takes it
      if (issue) begin
        l2_pend_q <= !l2_req_ready_i;
      end else if (l2_req_ready_i) begin
        l2_pend_q <= 1'b0;
      end
      if (issue && is_load) begin
        mshr_busy_q <= 1'b1;
      end else if (refill_done) begin
        mshr_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      l2_we_q    <= is_store;
      l2_addr_q  <= l2_addr;
      l2_wdata_q <= stage.wdata;
      l2_be_q    <= stage.be;
    end
    if (issue && is_load) begin
      mshr_way_q  <= victim_vec;
      mshr_addr_q <= stage.addr[`DC_ADDR_W-1:`DC_LOFF_W];
    end
  end

  // Victim bits, cleared by the sweep, flipped per refill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_q <= '0;
    end else if (stage.op == OpSweep) begin
      victim_q[set] <= 1'b0;
    end else if (refill_done) begin
      victim_q[set] <= !victim_q[set];
    end
  end

endmodule

// ==== source/dcache_top.sv ====
// ###################################################################
// Two-way L1 data cache, d0 and d1 stages with way memories
// Requests wait for the reset sweep of all sets
// L2 answers carry one full line per transfer
// ###################################################################
`include "dcache_params.svh"

module dcache_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clr_i,
  input  logic                   lsq_req_valid_i,
  output logic                   lsq_req_ready_o,
  input  logic                   lsq_req_we_i,
  input  dcache_pkg::addr_t      lsq_req_addr_i,
  input  dcache_pkg::word_t      lsq_req_wdata_i,
  input  dcache_pkg::word_be_t   lsq_req_be_i,
  output logic                   lsq_rsp_valid_o,
  output logic                   lsq_rsp_hit_o,
  output dcache_pkg::word_t      lsq_rsp_data_o,
  output logic                   l2_req_valid_o,
  input  logic                   l2_req_ready_i,
  output logic                   l2_req_we_o,
  output dcache_pkg::addr_t      l2_req_addr_o,
  output dcache_pkg::word_t      l2_req_wdata_o,
  output dcache_pkg::word_be_t   l2_req_be_o,
  input  logic                   l2_ans_valid_i,
  output logic                   l2_ans_ready_o,
  input  dcache_pkg::line_addr_t l2_ans_addr_i,
  input  dcache_pkg::line_t      l2_ans_line_i,
  output logic                   lsq_wup_valid_o,
  output dcache_pkg::line_addr_t lsq_wup_addr_o
);
  import dcache_pkg::*;

  dcache_stage_if stage ();

  // Shared write port toward every way
  set_idx_t   mem_set;
  tag_t       mem_tag;
  logic       mem_valid;
  line_t      mem_line;
  line_be_t   mem_line_be;
  way_vec_t   mem_tag_we;
  way_vec_t   mem_data_en;

  // Registered way outputs
  tag_t  [`DC_WAYS-1:0] tag_vec;
  way_vec_t             valid_vec;
  line_t [`DC_WAYS-1:0] line_vec;

  way_vec_t   mshr_way;
  line_addr_t mshr_addr;

  dcache_d0 d0_inst (
    .clk_i, .rst_ni, .clr_i,
    .lsq_req_valid_i, .lsq_req_ready_o, .lsq_req_we_i,
    .lsq_req_addr_i, .lsq_req_wdata_i, .lsq_req_be_i,
    .l2_ans_valid_i, .l2_ans_ready_o, .l2_ans_addr_i, .l2_ans_line_i,
    .lsq_wup_valid_o, .lsq_wup_addr_o,
    .stage         (stage.d0),
    .mshr_way_i    (mshr_way),
    .mshr_addr_i   (mshr_addr),
    .mem_set_o     (mem_set),
    .mem_tag_o     (mem_tag),
    .mem_valid_o   (mem_valid),
    .mem_line_o    (mem_line),
    .mem_line_be_o (mem_line_be),
    .mem_tag_we_o  (mem_tag_we),
    .mem_data_en_o (mem_data_en)
  );

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    dcache_way_mem way_mem_inst (
      .clk_i,
      .set_i     (mem_set),
      .tag_i     (mem_tag),
      .valid_i   (mem_valid),
      .line_i    (mem_line),
      .line_be_i (mem_line_be),
      .tag_we_i  (mem_tag_we[w]),
      .data_en_i (mem_data_en[w]),
      .tag_o     (tag_vec[w]),
      .valid_o   (valid_vec[w]),
      .line_o    (line_vec[w])
    );
  end

  dcache_d1 d1_inst (
    .clk_i, .rst_ni, .clr_i,
    .stage       (stage.d1),
    .tag_vec_i   (tag_vec),
    .valid_vec_i (valid_vec),
    .line_vec_i  (line_vec),
    .lsq_rsp_valid_o, .lsq_rsp_hit_o, .lsq_rsp_data_o,
    .l2_req_valid_o, .l2_req_ready_i, .l2_req_we_o,
    .l2_req_addr_o, .l2_req_wdata_o, .l2_req_be_o,
    .mshr_way_o  (mshr_way),
    .mshr_addr_o (mshr_addr)
  );

endmodule

// ==== bench/dcache_tb_sva.sv ====
// ######################################################################
// Assertions bound to the cache top level
// Sweep length assumes DC_SETS cycles after reset release
// ######################################################################
`include "dcache_params.svh"

module dcache_tb_sva (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   clr_i,
  input logic                   lsq_req_valid_i,
  input logic                   lsq_req_ready_o,
  input logic                   lsq_rsp_valid_o,
  input logic                   l2_req_valid_o,
  input logic                   l2_req_ready_i,
  input logic                   l2_req_we_o,
  input dcache_pkg::addr_t      l2_req_addr_o,
  input dcache_pkg::word_t      l2_req_wdata_o,
  input dcache_pkg::word_be_t   l2_req_be_o,
  input logic                   l2_ans_valid_i,
  input logic                   l2_ans_ready_o,
  input logic                   lsq_wup_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [5:0] cyc_q;

  // Cycles since reset, saturating past the sweep
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q <= '0;
    end else if (cyc_q < 6'(`DC_SETS)) begin
      cyc_q <= cyc_q + 1'b1;
    end
  end

  a_sweep_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cyc_q < 6'(`DC_SETS)) |-> !lsq_req_ready_o)
    else $error("LSQ ready during sweep");

  a_rsp_follows : assert property (@(posedge clk_i) disable iff (!rst_ni || clr_i)
    (lsq_req_valid_i && lsq_req_ready_o) |=> lsq_rsp_valid_o)
    else $error("missing LSQ response");

  a_l2_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (l2_req_valid_o && !l2_req_ready_i && !clr_i) |=>
      (l2_req_valid_o && $stable({l2_req_we_o, l2_req_addr_o, l2_req_wdata_o, l2_req_be_o})))
    else $error("L2 request changed under back-pressure");

  a_wup_with_ans : assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsq_wup_valid_o |-> (l2_ans_valid_i && l2_ans_ready_o))
    else $error("wake-up without accepted answer");

endmodule

bind dcache_top dcache_tb_sva dcache_tb_sva_inst (.*);

// ==== bench/dcache_tb.sv ====
// ######################################################################
// Directed testbench of the L1 data cache
// L2 model covers byte addresses below 1 KiB only
// L2 accepts requests at once unless a test holds back l2_req_ready_i
// ######################################################################
`include "dcache_params.svh"

module dcache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import dcache_pkg::*;

  localparam int max_cycles = `DC_SETS + 6 * 120;

  logic clk_i, rst_ni, clr_i;
  logic lsq_req_valid_i, lsq_req_ready_o, lsq_req_we_i;
  addr_t lsq_req_addr_i;
  word_t lsq_req_wdata_i;
  word_be_t lsq_req_be_i;
  logic lsq_rsp_valid_o, lsq_rsp_hit_o;
  word_t lsq_rsp_data_o;
  logic l2_req_valid_o, l2_req_ready_i, l2_req_we_o;
  addr_t l2_req_addr_o;
  word_t l2_req_wdata_o;
  word_be_t l2_req_be_o;
  logic l2_ans_valid_i, l2_ans_ready_o;
  line_addr_t l2_ans_addr_i;
  line_t l2_ans_line_i;
  logic lsq_wup_valid_o;
  line_addr_t lsq_wup_addr_o;

  // Shadow L2 contents, one word per entry
  word_t shadow [256];
  logic [31:0] lfsr_q;
  int errors, tests_run, tests_failed, cycles;

  // Snapshot of the response cycle
  logic rsp_hit, req_v, req_we;
  word_t rsp_data, req_wdata;
  addr_t req_addr;
  word_be_t req_be;

  dcache_top dcache_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // L2 word writes land in the shadow
  always @(posedge clk_i) begin
    if (l2_req_valid_o && l2_req_ready_i && l2_req_we_o) begin
      for (int b = 0; b < 4; b++) begin
        if (l2_req_be_o[b]) begin
          shadow[l2_req_addr_o[9:2]][8*b +: 8] = l2_req_wdata_o[8*b +: 8];
        end
      end
    end
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_q[0];
      lfsr_q = (lfsr_q >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic word_t merge(input word_t old, input word_t d, input word_be_t be);
    word_t r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = be[b] ? d[8*b +: 8] : old[8*b +: 8];
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // One LSQ request, returns at the response cycle
  task automatic access(input logic we, input addr_t addr, input word_t d, input word_be_t be);
    @(negedge clk_i);
    lsq_req_valid_i = 1'b1;
    lsq_req_we_i    = we;
    lsq_req_addr_i  = addr;
    lsq_req_wdata_i = d;
    lsq_req_be_i    = be;
    #1;
    while (!lsq_req_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    lsq_req_valid_i = 1'b0;
    check("lsq_rsp_valid_o", lsq_rsp_valid_o, 1);
    rsp_hit   = lsq_rsp_hit_o;
    rsp_data  = lsq_rsp_data_o;
    req_v     = l2_req_valid_o;
    req_we    = l2_req_we_o;
    req_addr  = l2_req_addr_o;
    req_wdata = l2_req_wdata_o;
    req_be    = l2_req_be_o;
  endtask

  // L2 answer built from the shadow line
  task automatic refill(input line_addr_t la);
    line_t line;
    for (int i = 0; i < `DC_WORDS; i++) begin
      line[32*i +: 32] = shadow[(la * 4 + i) % 256];
    end
    @(negedge clk_i);
    l2_ans_valid_i = 1'b1;
    l2_ans_addr_i  = la;
    l2_ans_line_i  = line;
    #1;
    while (!l2_ans_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    check("lsq_wup_valid_o", lsq_wup_valid_o, 1);
    check("lsq_wup_addr_o", lsq_wup_addr_o, la);
    @(posedge clk_i);
    @(negedge clk_i);
    l2_ans_valid_i = 1'b0;
  endtask

  task automatic load_expect(input addr_t addr, input logic hit, input word_t exp);
    access(1'b0, addr, '0, '0);
    check("lsq_rsp_hit_o", rsp_hit, hit);
    if (hit) check("lsq_rsp_data_o", rsp_data, exp);
  endtask

  task automatic report(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: fail", name);
    end
  endtask

  task automatic sweep_cold_miss();
    int e;
    e = errors;
    @(negedge clk_i);
    // Both readies held low by the sweep
    check("lsq_req_ready_o", lsq_req_ready_o, 0);
    check("l2_ans_ready_o", l2_ans_ready_o, 0);
    while (!lsq_req_ready_o) @(negedge clk_i);
    check("l2_ans_ready_o", l2_ans_ready_o, 1);
    access(1'b0, 32'h000, '0, '0);
    check("lsq_rsp_hit_o", rsp_hit, 0);
    check("l2_req_valid_o", req_v, 1);
    check("l2_req_we_o", req_we, 0);
    check("l2_req_addr_o", req_addr, 32'h000);
    report("sweep_and_cold_miss", e);
  endtask

  task automatic refill_then_hit();
    int e;
    e = errors;
    refill(28'h0);
    for (int w = 0; w < `DC_WORDS; w++) begin
      load_expect(addr_t'(4 * w), 1'b1, shadow[w]);
    end
    report("refill_and_hit", e);
  endtask

  task automatic store_hit_merge();
    int e;
    word_t d, exp;
    word_be_t be;
    e = errors;
    d = rand_bits(32);
    be = word_be_t'(rand_bits(4));
    exp = merge(shadow[1], d, be);
    access(1'b1, 32'h004, d, be);
    check("lsq_rsp_hit_o", rsp_hit, 1);
    check("l2_req_valid_o", req_v, 0);
    // Write-back owns d0 in the response cycle
    check("lsq_req_ready_o", lsq_req_ready_o, 0);
    check("l2_ans_ready_o", l2_ans_ready_o, 0);
    load_expect(32'h004, 1'b1, exp);
    check("l2_req_valid_o", req_v, 0);
    report("store_hit_byte_enables", e);
  endtask

  task automatic store_miss_no_alloc();
    int e;
    word_t d, exp;
    word_be_t be;
    e = errors;
    d = rand_bits(32);
    be = word_be_t'(rand_bits(4));
    exp = merge(shadow[41], d, be);
    access(1'b1, 32'h0a4, d, be);
    check("lsq_rsp_hit_o", rsp_hit, 0);
    check("l2_req_valid_o", req_v, 1);
    check("l2_req_we_o", req_we, 1);
    check("l2_req_addr_o", req_addr, 32'h0a4);
    check("l2_req_wdata_o", req_wdata, d);
    check("l2_req_be_o", req_be, be);
    load_expect(32'h0a4, 1'b0, '0);
    refill(28'h0a);
    load_expect(32'h0a4, 1'b1, exp);
    report("store_miss_no_allocate", e);
  endtask

  task automatic replace_victim();
    int e;
    e = errors;
    // Set 4 with tags 0, 1 and 2
    load_expect(32'h040, 1'b0, '0);
    refill(28'h04);
    load_expect(32'h140, 1'b0, '0);
    refill(28'h14);
    load_expect(32'h240, 1'b0, '0);
    refill(28'h24);
    // Victim bit back at way 0 after two refills
    load_expect(32'h240, 1'b1, shadow[8'h90]);
    load_expect(32'h140, 1'b1, shadow[8'h50]);
    load_expect(32'h040, 1'b0, '0);
    refill(28'h04);
    report("replacement", e);
  endtask

  task automatic backpressure_clear();
    int e;
    e = errors;
    @(negedge clk_i);
    l2_req_ready_i = 1'b0;
    access(1'b0, 32'h3c0, '0, '0);
    check("lsq_rsp_hit_o", rsp_hit, 0);
    lsq_req_valid_i = 1'b1;
    lsq_req_addr_i  = 32'h000;
    repeat (4) begin
      @(negedge clk_i);
      #1;
      check("l2_req_valid_o", l2_req_valid_o, 1);
      check("l2_req_addr_o", l2_req_addr_o, 32'h3c0);
      check("l2_req_we_o", l2_req_we_o, 0);
      check("lsq_req_ready_o", lsq_req_ready_o, 0);
      check("lsq_rsp_valid_o", lsq_rsp_valid_o, 0);
    end
    @(negedge clk_i);
    lsq_req_valid_i = 1'b0;
    clr_i = 1'b1;
    @(negedge clk_i);
    clr_i = 1'b0;
    l2_req_ready_i = 1'b1;
    check("l2_req_valid_o", l2_req_valid_o, 0);
    load_expect(32'h000, 1'b1, shadow[0]);
    report("backpressure_and_clear", e);
  endtask

  initial begin
    rst_ni = 1'b0;
    clr_i = 1'b0;
    lsq_req_valid_i = 1'b0;
    lsq_req_we_i = 1'b0;
    lsq_req_addr_i = '0;
    lsq_req_wdata_i = '0;
    lsq_req_be_i = '0;
    l2_req_ready_i = 1'b1;
    l2_ans_valid_i = 1'b0;
    l2_ans_addr_i = '0;
    l2_ans_line_i = '0;
    lfsr_q = 32'h6de4_d42d;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = rand_bits(32);
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    sweep_cold_miss();
    refill_then_hit();
    store_hit_merge();
    store_miss_no_alloc();
    replace_victim();
    backpressure_clear();
    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+source
+incdir+bench
source/dcache_pkg.sv
source/dcache_stage_if.sv
source/dcache_d0_arbiter.sv
source/dcache_d0_mem_ctrl.sv
source/dcache_d0.sv
source/dcache_way_mem.sv
source/dcache_d1.sv
source/dcache_top.sv
bench/dcache_tb_sva.sv
bench/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the L1 data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
